// File: Bender.yml
package:
  name: alu_rs

sources:
  - alu_rs_pkg.sv
  - issue_decode.sv
  - reservation_station.sv
  - issue_select.sv
  - exec_unit.sv
  - alu_rs_top.sv
  - target: test
    files:
      - tb_alu_rs_chk.sv
      - tb_alu_rs.sv

// File: alu_rs_pkg.sv
package alu_rs_pkg;

	// data path width
	localparam int xlen = 32;
	// rob tag width, 16 tags in flight
	localparam int tag_w = 4;

	// major opcodes seen by the integer path
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv_opcode_e;

	// funct3 of op_imm and op_reg
	typedef enum logic [2:0] {
		add  = 3'b000,
		sll  = 3'b001,
		slt  = 3'b010,
		sltu = 3'b011,
		axor = 3'b100,
		sr   = 3'b101,
		aor  = 3'b110,
		aand = 3'b111
	} arith_f3_e;

	// alu operations
	// add, sll, xor, srl, or, and share the funct3 code
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_op_e;

	// compare operations, encoded as the branch funct3
	typedef enum logic [2:0] {
		cmp_beq  = 3'b000,
		cmp_bne  = 3'b001,
		cmp_blt  = 3'b100,
		cmp_bge  = 3'b101,
		cmp_bltu = 3'b110,
		cmp_bgeu = 3'b111
	} cmp_op_e;

	// one instruction word, read as r-type fields or as an immediate body
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			rv_opcode_e opcode;
		} r;
		struct packed {
			logic [24:0] body;
			rv_opcode_e  opcode;
		} i;
	} insn_u;

	// survivors run from front up to stop, wrapping around
	// front equal to stop leaves nothing alive
	function automatic logic in_window(input logic [tag_w-1:0] front,
			input logic [tag_w-1:0] stop, input logic [tag_w-1:0] tag);
		if (front < stop)
			return (tag >= front) && (tag < stop);
		if (front > stop)
			return (tag >= front) || (tag < stop);
		return 1'b0;
	endfunction

endpackage

// File: alu_rs_top.sv
`timescale 1ns/1ps

module alu_rs_top import alu_rs_pkg::*; #(
	parameter  int rs_size = 8,
	localparam int cnt_w   = $clog2(rs_size + 1)
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             issue_valid,
	input  logic [xlen-1:0]  issue_pc,
	input  insn_u            issue_insn,
	input  logic [tag_w-1:0] issue_tag,
	input  logic             src1_busy,
	input  logic [xlen-1:0]  src1_val,
	input  logic             src2_busy,
	input  logic [xlen-1:0]  src2_val,
	input  logic             rob_bc_valid,
	input  logic [tag_w-1:0] rob_bc_tag,
	input  logic [xlen-1:0]  rob_bc_value,
	input  logic             flush_valid,
	input  logic [tag_w-1:0] flush_front,
	input  logic [tag_w-1:0] flush_tag,
	output logic             result_valid,
	output logic [tag_w-1:0] result_tag,
	output logic [xlen-1:0]  result_value,
	output logic [cnt_w-1:0] free_count
);

	localparam int idx_w = $clog2(rs_size);

	// decode to station
	logic             dec_valid;
	logic [tag_w-1:0] dec_tag;
	alu_op_e          dec_alu_op;
	cmp_op_e          dec_cmp_op;
	logic             dec_is_cmp;
	logic             dec_busy1;
	logic [xlen-1:0]  dec_op1;
	logic             dec_busy2;
	logic [xlen-1:0]  dec_op2;

	// station to select
	logic [rs_size-1:0] ready;
	logic [tag_w-1:0] ent_tag [rs_size];
	alu_op_e          ent_alu_op [rs_size];
	cmp_op_e          ent_cmp_op [rs_size];
	logic [rs_size-1:0] ent_is_cmp;
	logic [xlen-1:0]  ent_a [rs_size];
	logic [xlen-1:0]  ent_b [rs_size];
	logic             take_valid;
	logic [idx_w-1:0] take_index;

	// select to execute
	logic             disp_valid;
	logic [tag_w-1:0] disp_tag;
	alu_op_e          disp_alu_op;
	cmp_op_e          disp_cmp_op;
	logic             disp_is_cmp;
	logic [xlen-1:0]  disp_a;
	logic [xlen-1:0]  disp_b;

	issue_decode u_issue_decode (
		.clk, .rst,
		.issue_valid, .issue_pc, .issue_insn, .issue_tag,
		.src1_busy, .src1_val, .src2_busy, .src2_val,
		.flush_valid, .flush_front, .flush_tag,
		.dec_valid, .dec_tag, .dec_alu_op, .dec_cmp_op, .dec_is_cmp,
		.dec_busy1, .dec_op1, .dec_busy2, .dec_op2
	);

	// result bus feeds back into the station as the cdb
	reservation_station #(.rs_size(rs_size)) u_reservation_station (
		.clk, .rst,
		.dec_valid, .dec_tag, .dec_alu_op, .dec_cmp_op, .dec_is_cmp,
		.dec_busy1, .dec_op1, .dec_busy2, .dec_op2,
		.cdb_valid(result_valid), .cdb_tag(result_tag), .cdb_value(result_value),
		.rob_bc_valid, .rob_bc_tag, .rob_bc_value,
		.flush_valid, .flush_front, .flush_tag,
		.take_valid, .take_index,
		.ready, .ent_tag, .ent_alu_op, .ent_cmp_op, .ent_is_cmp, .ent_a, .ent_b,
		.free_count
	);

	issue_select #(.rs_size(rs_size)) u_issue_select (
		.clk, .rst,
		.ready, .ent_tag, .ent_alu_op, .ent_cmp_op, .ent_is_cmp, .ent_a, .ent_b,
		.flush_valid, .flush_front, .flush_tag,
		.take_valid, .take_index,
		.disp_valid, .disp_tag, .disp_alu_op, .disp_cmp_op, .disp_is_cmp,
		.disp_a, .disp_b
	);

	exec_unit u_exec_unit (
		.clk, .rst,
		.disp_valid, .disp_tag, .disp_alu_op, .disp_cmp_op, .disp_is_cmp,
		.disp_a, .disp_b,
		.flush_valid, .flush_front, .flush_tag,
		.cdb_valid(result_valid), .cdb_tag(result_tag), .cdb_value(result_value)
	);

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps

module exec_unit import alu_rs_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             disp_valid,
	input  logic [tag_w-1:0] disp_tag,
	input  alu_op_e          disp_alu_op,
	input  cmp_op_e          disp_cmp_op,
	input  logic             disp_is_cmp,
	input  logic [xlen-1:0]  disp_a,
	input  logic [xlen-1:0]  disp_b,
	input  logic             flush_valid,
	input  logic [tag_w-1:0] flush_front,
	input  logic [tag_w-1:0] flush_tag,
	output logic             cdb_valid,
	output logic [tag_w-1:0] cdb_tag,
	output logic [xlen-1:0]  cdb_value
);

	logic [4:0]      shamt;
	logic [xlen-1:0] alu_res;
	logic            cmp_res;
	logic [xlen-1:0] result;

	// shifts use only the low five bits
	assign shamt = disp_b[4:0];

	always_comb begin
		case (disp_alu_op)
			alu_add: alu_res = disp_a + disp_b;
			alu_sub: alu_res = disp_a - disp_b;
			alu_sll: alu_res = disp_a << shamt;
			alu_srl: alu_res = disp_a >> shamt;
			alu_sra: alu_res = $unsigned($signed(disp_a) >>> shamt);
			alu_xor: alu_res = disp_a ^ disp_b;
			alu_or:  alu_res = disp_a | disp_b;
			alu_and: alu_res = disp_a & disp_b;
			default: alu_res = '0;
		endcase
	end

	always_comb begin
		case (disp_cmp_op)
			cmp_beq:  cmp_res = disp_a == disp_b;
			cmp_bne:  cmp_res = disp_a != disp_b;
			cmp_blt:  cmp_res = $signed(disp_a) < $signed(disp_b);
			cmp_bge:  cmp_res = $signed(disp_a) >= $signed(disp_b);
			cmp_bltu: cmp_res = disp_a < disp_b;
			cmp_bgeu: cmp_res = disp_a >= disp_b;
			default:  cmp_res = 1'b0;
		endcase
	end

	// compare outcome goes out zero extended in bit 0
	assign result = disp_is_cmp ? {{(xlen - 1){1'b0}}, cmp_res} : alu_res;

	// broadcast strobe, squashed results are never sent
	always_ff @(posedge clk) begin
		if (rst)
			cdb_valid <= 1'b0;
		else if (flush_valid)
			cdb_valid <= disp_valid && in_window(flush_front, flush_tag, disp_tag);
		else
			cdb_valid <= disp_valid;
	end

	always_ff @(posedge clk) begin
		if (disp_valid) begin
			cdb_tag   <= disp_tag;
			cdb_value <= result;
		end
	end

endmodule

// File: issue_decode.sv
`timescale 1ns/1ps

module issue_decode import alu_rs_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             issue_valid,
	input  logic [xlen-1:0]  issue_pc,
	input  insn_u            issue_insn,
	input  logic [tag_w-1:0] issue_tag,
	input  logic             src1_busy,
	input  logic [xlen-1:0]  src1_val,
	input  logic             src2_busy,
	input  logic [xlen-1:0]  src2_val,
	input  logic             flush_valid,
	input  logic [tag_w-1:0] flush_front,
	input  logic [tag_w-1:0] flush_tag,
	output logic             dec_valid,
	output logic [tag_w-1:0] dec_tag,
	output alu_op_e          dec_alu_op,
	output cmp_op_e          dec_cmp_op,
	output logic             dec_is_cmp,
	output logic             dec_busy1,
	output logic [xlen-1:0]  dec_op1,
	output logic             dec_busy2,
	output logic [xlen-1:0]  dec_op2
);

	logic [xlen-1:0] i_imm;
	logic [xlen-1:0] u_imm;
	logic [xlen-1:0] j_imm;
	arith_f3_e       f3;
	// funct7 bit 5 picks sub and sra
	logic            alt;
	alu_op_e         alu_op_d;
	cmp_op_e         cmp_op_d;
	logic            is_cmp_d;
	logic            busy1_d;
	logic [xlen-1:0] op1_d;
	logic            busy2_d;
	logic [xlen-1:0] op2_d;

	// immediates out of the 25 bit body, body[24] is insn[31]
	assign i_imm = {{20{issue_insn.i.body[24]}}, issue_insn.i.body[24:13]};
	assign u_imm = {issue_insn.i.body[24:5], 12'b0};
	assign j_imm = {{11{issue_insn.i.body[24]}}, issue_insn.i.body[24],
		issue_insn.i.body[12:5], issue_insn.i.body[13], issue_insn.i.body[23:14], 1'b0};

	assign f3  = arith_f3_e'(issue_insn.r.funct3);
	assign alt = issue_insn.r.funct7[5];

	always_comb begin
		// register operands pass through unless the opcode says otherwise
		alu_op_d = alu_add;
		cmp_op_d = cmp_beq;
		is_cmp_d = 1'b0;
		busy1_d  = src1_busy;
		op1_d    = src1_val;
		busy2_d  = src2_busy;
		op2_d    = src2_val;
		case (issue_insn.r.opcode)
			op_lui: begin
				busy1_d = 1'b0;
				op1_d   = u_imm;
				busy2_d = 1'b0;
				op2_d   = '0;
			end
			op_auipc: begin
				busy1_d = 1'b0;
				op1_d   = issue_pc;
				busy2_d = 1'b0;
				op2_d   = u_imm;
			end
			op_jal: begin
				busy1_d = 1'b0;
				op1_d   = issue_pc;
				busy2_d = 1'b0;
				op2_d   = j_imm;
			end
			op_jalr: begin
				busy2_d = 1'b0;
				op2_d   = i_imm;
			end
			op_br: begin
				is_cmp_d = 1'b1;
				cmp_op_d = cmp_op_e'(issue_insn.r.funct3);
			end
			op_imm, op_reg: begin
				// immediate form replaces rs2
				if (issue_insn.r.opcode == op_imm) begin
					busy2_d = 1'b0;
					op2_d   = i_imm;
				end
				case (f3)
					add:  alu_op_d = (issue_insn.r.opcode == op_reg && alt) ? alu_sub : alu_add;
					sll:  alu_op_d = alu_sll;
					slt: begin
						is_cmp_d = 1'b1;
						cmp_op_d = cmp_blt;
					end
					sltu: begin
						is_cmp_d = 1'b1;
						cmp_op_d = cmp_bltu;
					end
					axor: alu_op_d = alu_xor;
					sr:   alu_op_d = alt ? alu_sra : alu_srl;
					aor:  alu_op_d = alu_or;
					aand: alu_op_d = alu_and;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// valid strobe, an issue outside the flush window is dropped
	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 1'b0;
		else if (flush_valid)
			dec_valid <= issue_valid && in_window(flush_front, flush_tag, issue_tag);
		else
			dec_valid <= issue_valid;
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			dec_tag    <= issue_tag;
			dec_alu_op <= alu_op_d;
			dec_cmp_op <= cmp_op_d;
			dec_is_cmp <= is_cmp_d;
			dec_busy1  <= busy1_d;
			dec_op1    <= op1_d;
			dec_busy2  <= busy2_d;
			dec_op2    <= op2_d;
		end
	end

endmodule

// File: issue_select.sv
`timescale 1ns/1ps

module issue_select import alu_rs_pkg::*; #(
	parameter  int rs_size = 8,
	localparam int idx_w   = $clog2(rs_size)
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [rs_size-1:0] ready,
	input  logic [tag_w-1:0] ent_tag [rs_size],
	input  alu_op_e          ent_alu_op [rs_size],
	input  cmp_op_e          ent_cmp_op [rs_size],
	input  logic [rs_size-1:0] ent_is_cmp,
	input  logic [xlen-1:0]  ent_a [rs_size],
	input  logic [xlen-1:0]  ent_b [rs_size],
	input  logic             flush_valid,
	input  logic [tag_w-1:0] flush_front,
	input  logic [tag_w-1:0] flush_tag,
	output logic             take_valid,
	output logic [idx_w-1:0] take_index,
	output logic             disp_valid,
	output logic [tag_w-1:0] disp_tag,
	output alu_op_e          disp_alu_op,
	output cmp_op_e          disp_cmp_op,
	output logic             disp_is_cmp,
	output logic [xlen-1:0]  disp_a,
	output logic [xlen-1:0]  disp_b
);

	// priority encoder, lowest index wins
	always_comb begin
		take_valid = 1'b0;
		take_index = '0;
		for (int i = rs_size - 1; i >= 0; i--) begin
			if (ready[i]) begin
				take_valid = 1'b1;
				take_index = idx_w'(i);
			end
		end
	end

	// dispatch strobe, a squashed pick never reaches execute
	always_ff @(posedge clk) begin
		if (rst)
			disp_valid <= 1'b0;
		else if (flush_valid)
			disp_valid <= take_valid && in_window(flush_front, flush_tag, ent_tag[take_index]);
		else
			disp_valid <= take_valid;
	end

	always_ff @(posedge clk) begin
		if (take_valid) begin
			disp_tag    <= ent_tag[take_index];
			disp_alu_op <= ent_alu_op[take_index];
			disp_cmp_op <= ent_cmp_op[take_index];
			disp_is_cmp <= ent_is_cmp[take_index];
			disp_a      <= ent_a[take_index];
			disp_b      <= ent_b[take_index];
		end
	end

endmodule

// File: reservation_station.sv
`timescale 1ns/1ps

module reservation_station import alu_rs_pkg::*; #(
	parameter  int rs_size = 8,
	localparam int idx_w   = $clog2(rs_size),
	localparam int cnt_w   = $clog2(rs_size + 1)
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             dec_valid,
	input  logic [tag_w-1:0] dec_tag,
	input  alu_op_e          dec_alu_op,
	input  cmp_op_e          dec_cmp_op,
	input  logic             dec_is_cmp,
	input  logic             dec_busy1,
	input  logic [xlen-1:0]  dec_op1,
	input  logic             dec_busy2,
	input  logic [xlen-1:0]  dec_op2,
	input  logic             cdb_valid,
	input  logic [tag_w-1:0] cdb_tag,
	input  logic [xlen-1:0]  cdb_value,
	input  logic             rob_bc_valid,
	input  logic [tag_w-1:0] rob_bc_tag,
	input  logic [xlen-1:0]  rob_bc_value,
	input  logic             flush_valid,
	input  logic [tag_w-1:0] flush_front,
	input  logic [tag_w-1:0] flush_tag,
	input  logic             take_valid,
	input  logic [idx_w-1:0] take_index,
	output logic [rs_size-1:0] ready,
	output logic [tag_w-1:0] ent_tag [rs_size],
	output alu_op_e          ent_alu_op [rs_size],
	output cmp_op_e          ent_cmp_op [rs_size],
	output logic [rs_size-1:0] ent_is_cmp,
	output logic [xlen-1:0]  ent_a [rs_size],
	output logic [xlen-1:0]  ent_b [rs_size],
	output logic [cnt_w-1:0] free_count
);

	logic [rs_size-1:0] ent_valid;
	// operand holds a tag while its busy bit is set
	logic [rs_size-1:0] ent_busy1;
	logic [rs_size-1:0] ent_busy2;
	logic               has_free;
	logic [idx_w-1:0]   free_idx;
	logic               dec_write;

	// capture an operand when either broadcast carries its tag
	// the own bus wins if both match
	function automatic logic [xlen:0] wake(input logic busy, input logic [xlen-1:0] val);
		if (busy && cdb_valid && val[tag_w-1:0] == cdb_tag)
			return {1'b0, cdb_value};
		if (busy && rob_bc_valid && val[tag_w-1:0] == rob_bc_tag)
			return {1'b0, rob_bc_value};
		return {busy, val};
	endfunction

	// lowest free slot and count of free slots
	always_comb begin
		has_free   = 1'b0;
		free_idx   = '0;
		free_count = '0;
		for (int i = rs_size - 1; i >= 0; i--) begin
			if (!ent_valid[i]) begin
				has_free = 1'b1;
				free_idx = idx_w'(i);
			end
		end
		for (int i = 0; i < rs_size; i++) begin
			if (!ent_valid[i])
				free_count = free_count + cnt_w'(1);
		end
	end

	// ready once both operands hold values
	always_comb begin
		for (int i = 0; i < rs_size; i++)
			ready[i] = ent_valid[i] && !ent_busy1[i] && !ent_busy2[i];
	end

	// a decoded item still has to survive a flush in the same cycle
	assign dec_write = dec_valid && has_free &&
		(!flush_valid || in_window(flush_front, flush_tag, dec_tag));

	// occupancy
	always_ff @(posedge clk) begin
		if (rst) begin
			ent_valid <= '0;
		end else begin
			for (int i = 0; i < rs_size; i++) begin
				// dispatched entry leaves
				if (take_valid && take_index == idx_w'(i))
					ent_valid[i] <= 1'b0;
				// squashed entry leaves
				if (flush_valid && !in_window(flush_front, flush_tag, ent_tag[i]))
					ent_valid[i] <= 1'b0;
			end
			// free slot is never the taken one
			if (dec_write)
				ent_valid[free_idx] <= 1'b1;
		end
	end

	// entry payload and operand wakeup
	always_ff @(posedge clk) begin
		for (int i = 0; i < rs_size; i++) begin
			{ent_busy1[i], ent_a[i]} <= wake(ent_busy1[i], ent_a[i]);
			{ent_busy2[i], ent_b[i]} <= wake(ent_busy2[i], ent_b[i]);
		end
		if (dec_write) begin
			ent_tag[free_idx]    <= dec_tag;
			ent_alu_op[free_idx] <= dec_alu_op;
			ent_cmp_op[free_idx] <= dec_cmp_op;
			ent_is_cmp[free_idx] <= dec_is_cmp;
			// a broadcast on the write edge is caught here
			{ent_busy1[free_idx], ent_a[free_idx]} <= wake(dec_busy1, dec_op1);
			{ent_busy2[free_idx], ent_b[free_idx]} <= wake(dec_busy2, dec_op2);
		end
	end

endmodule

// File: tb_alu_rs.sv
`timescale 1ns/1ps

module tb_alu_rs import alu_rs_pkg::*; ();

	localparam int rs_size = 8;
	localparam int n_tags  = 1 << tag_w;
	// rough opcode mix weighted toward register ops
	localparam int roll_kind [10] = '{0, 0, 0, 1, 1, 2, 3, 4, 5, 6};

	logic             clk = 1'b0;
	logic             rst;
	logic             issue_valid;
	logic [xlen-1:0]  issue_pc;
	insn_u            issue_insn;
	logic [tag_w-1:0] issue_tag;
	logic             src1_busy;
	logic [xlen-1:0]  src1_val;
	logic             src2_busy;
	logic [xlen-1:0]  src2_val;
	logic             rob_bc_valid;
	logic [tag_w-1:0] rob_bc_tag;
	logic [xlen-1:0]  rob_bc_value;
	logic             flush_valid;
	logic [tag_w-1:0] flush_front;
	logic [tag_w-1:0] flush_tag;
	logic             result_valid;
	logic [tag_w-1:0] result_tag;
	logic [xlen-1:0]  result_value;
	logic [$clog2(rs_size + 1)-1:0] free_count;

	// rob model with one slot per tag
	logic [xlen-1:0]  exp_val [n_tags];
	logic [xlen-1:0]  pc_of [n_tags];
	logic [31:0]      insn_of [n_tags];
	logic [xlen-1:0]  val1 [n_tags];
	logic [xlen-1:0]  val2 [n_tags];
	logic [tag_w-1:0] src1_tag [n_tags];
	logic [tag_w-1:0] src2_tag [n_tags];
	bit               is_ext [n_tags];
	bit               dep1 [n_tags];
	bit               dep2 [n_tags];
	// pending marks a result still owed on the bus
	bit               pending [n_tags];
	// done marks a value already known to consumers
	bit               done [n_tags];
	bit               dropped [n_tags];
	int               issue_step [n_tags];
	logic [n_tags-1:0] hold_bc;
	logic [tag_w-1:0] batch [$];
	logic [tag_w-1:0] next_tag = '0;
	int               next_alu;
	int               step_no = 0;
	int               issued_count = 0;
	int               cycle_count = 0;
	int               err_value = 0;
	int               err_tag = 0;
	int               err_latency = 0;
	int               err_drain = 0;
	bit               lone_mode;
	bit               bc_enable;

	alu_rs_top #(.rs_size(rs_size)) u_alu_rs_top (.*);

	bind reservation_station tb_alu_rs_chk #(.rs_size(rs_size)) u_rs_chk (
		.clk(clk), .rst(rst), .take_valid(take_valid), .take_index(take_index),
		.ready(ready), .dec_valid(dec_valid), .free_count(free_count), .cdb_valid(cdb_valid)
	);

	always #4 clk = ~clk;

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// reference result straight from the rv32i field layout
	function automatic logic [31:0] model_result(input logic [31:0] pc, input logic [31:0] w,
			input logic [31:0] r1, input logic [31:0] r2);
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic        alt;
		logic [31:0] imm_i;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [31:0] b;
		opc   = w[6:0];
		f3    = w[14:12];
		alt   = w[30];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_u = {w[31:12], 12'b0};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		// second alu input is the immediate for op_imm
		b     = (opc == op_imm) ? imm_i : r2;
		case (opc)
			op_lui:   return imm_u;
			op_auipc: return pc + imm_u;
			op_jal:   return pc + imm_j;
			op_jalr:  return r1 + imm_i;
			op_br:    return {31'b0, branch_taken(f3, r1, r2)};
			default: begin
				case (f3)
					3'd0: return (opc == op_reg && alt) ? r1 - b : r1 + b;
					3'd1: return r1 << b[4:0];
					3'd2: return {31'b0, $signed(r1) < $signed(b)};
					3'd3: return {31'b0, r1 < b};
					3'd4: return r1 ^ b;
					3'd5: return alt ? $unsigned($signed(r1) >>> b[4:0]) : r1 >> b[4:0];
					3'd6: return r1 | b;
					default: return r1 & b;
				endcase
			end
		endcase
	endfunction

	// small values make equal compares likely
	function automatic logic [31:0] rand_operand();
		if ($urandom % 3 == 0)
			return $urandom % 8;
		return $urandom;
	endfunction

	function automatic logic [31:0] make_insn(input int kind);
		logic [6:0]  opcs [7];
		logic [2:0]  br_f3 [6];
		logic [31:0] w;
		opcs  = '{op_reg, op_imm, op_br, op_jalr, op_lui, op_auipc, op_jal};
		br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		w       = $urandom;
		w[6:0]  = opcs[kind];
		// only funct7 bit 5 is meaningful for register ops
		if (kind == 0)
			w[31:25] = {1'b0, w[30], 5'b0};
		if (kind == 2)
			w[14:12] = br_f3[$urandom % 6];
		return w;
	endfunction

	// a source is a ready value or an earlier tag of the batch
	task automatic pick_source(input int j, input bit force_dep, output bit dep,
			output logic [tag_w-1:0] st, output logic [xlen-1:0] v);
		dep = force_dep || (j > 0 && !lone_mode && $urandom % 2 == 1);
		st  = force_dep ? batch[0] : (j > 0 ? batch[$urandom % j] : '0);
		v   = dep ? exp_val[st] : rand_operand();
	endtask

	// mode 0 is a single lone op
	// mode 1 mixes ops and external values
	// mode 2 blocks everything behind one external value for the flush test
	task automatic build_batch(input int mode);
		int n;
		int kind;
		logic [tag_w-1:0] t;
		batch.delete();
		next_alu = 0;
		n = (mode == 0) ? 1 : (mode == 2) ? 2 + $urandom % 6 : 1 + $urandom % 12;
		for (int j = 0; j < n; j++) begin
			t = next_tag;
			next_tag++;
			batch.push_back(t);
			done[t]    = 1'b0;
			dropped[t] = 1'b0;
			is_ext[t]  = (mode == 2 && j == 0) || (mode == 1 && $urandom % 4 == 0);
			pending[t] = !is_ext[t];
			if (is_ext[t]) begin
				exp_val[t] = rand_operand();
			end else begin
				kind       = (mode == 2) ? $urandom % 4 : roll_kind[$urandom % 10];
				insn_of[t] = make_insn(kind);
				pc_of[t]   = $urandom & 32'hffff_fffc;
				pick_source(j, mode == 2, dep1[t], src1_tag[t], val1[t]);
				pick_source(j, 1'b0, dep2[t], src2_tag[t], val2[t]);
				exp_val[t] = model_result(pc_of[t], insn_of[t], val1[t], val2[t]);
			end
		end
	endtask

	task automatic sample_result();
		logic [tag_w-1:0] t;
		if (result_valid) begin
			t = result_tag;
			assert (pending[t]) else begin
				err_tag++;
				$display("error at %0t: result for unexpected tag %0d", $time, t);
			end
			if (pending[t]) begin
				assert (result_value == exp_val[t]) else begin
					err_value++;
					$display("error at %0t: tag %0d gave %h, expected %h",
						$time, t, result_value, exp_val[t]);
				end
				assert (!lone_mode || step_no - issue_step[t] == 4) else begin
					err_latency++;
					$display("lone instruction with tag %0d took %0d cycles instead of 4",
						t, step_no - issue_step[t]);
				end
				pending[t] = 1'b0;
				done[t]    = 1'b1;
			end
		end
	endtask

	function automatic bit alu_left();
		while (next_alu < batch.size() && is_ext[batch[next_alu]])
			next_alu++;
		return next_alu < batch.size();
	endfunction

	function automatic bit batch_busy();
		foreach (batch[i]) begin
			if (pending[batch[i]])
				return 1'b1;
			if (is_ext[batch[i]] && !done[batch[i]] && !dropped[batch[i]])
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// one falling edge checks the bus and then drives issue and broadcast
	task automatic cycle_step(input bit issue_ok);
		logic [tag_w-1:0] t;
		bit               sent;
		@(negedge clk);
		step_no++;
		sample_result();
		issue_valid  = 1'b0;
		rob_bc_valid = 1'b0;
		flush_valid  = 1'b0;
		hold_bc      = '0;
		sent         = 1'b0;
		// decode may hold one item that free_count does not show yet
		if (issue_ok && alu_left() && free_count >= 2 && $urandom % 4 != 0) begin
			t = batch[next_alu];
			next_alu++;
			issue_valid = 1'b1;
			issue_pc    = pc_of[t];
			issue_insn  = insn_of[t];
			issue_tag   = t;
			src1_busy   = dep1[t] && !done[src1_tag[t]];
			src1_val    = src1_busy ? xlen'(src1_tag[t]) : val1[t];
			src2_busy   = dep2[t] && !done[src2_tag[t]];
			src2_val    = src2_busy ? xlen'(src2_tag[t]) : val2[t];
			// a broadcast now would pass before decode writes the entry
			if (src1_busy)
				hold_bc[src1_tag[t]] = 1'b1;
			if (src2_busy)
				hold_bc[src2_tag[t]] = 1'b1;
			issue_step[t] = step_no;
			issued_count++;
		end
		if (bc_enable) begin
			foreach (batch[i]) begin
				t = batch[i];
				if (!sent && is_ext[t] && !done[t] && !dropped[t] && !hold_bc[t] &&
						$urandom % 3 == 0) begin
					rob_bc_valid = 1'b1;
					rob_bc_tag   = t;
					rob_bc_value = exp_val[t];
					done[t]      = 1'b1;
					sent         = 1'b1;
				end
			end
		end
	endtask

	task automatic run_batch(input int mode);
		int k;
		lone_mode = (mode == 0);
		build_batch(mode);
		if (mode == 2) begin
			// everything waits on batch[0] so nothing leaves before the flush
			bc_enable = 1'b0;
			while (alu_left())
				cycle_step(1'b1);
			repeat ($urandom % 3)
				cycle_step(1'b0);
			cycle_step(1'b0);
			k           = 1 + $urandom % batch.size();
			flush_valid = 1'b1;
			flush_front = batch[0];
			flush_tag   = batch[0] + tag_w'(k);
			for (int i = k; i < batch.size(); i++) begin
				dropped[batch[i]] = 1'b1;
				pending[batch[i]] = 1'b0;
			end
		end
		bc_enable = 1'b1;
		while (batch_busy())
			cycle_step(1'b1);
		// idle tail also catches late results of squashed tags
		repeat (6)
			cycle_step(1'b0);
		assert (free_count == rs_size) else begin
			err_drain++;
			$display("error at %0t: free count %0d after drain, expected %0d",
				$time, free_count, rs_size);
		end
	endtask

	initial begin
		void'($urandom(32'hc9ee_81ba));
		rst          = 1'b1;
		issue_valid  = 1'b0;
		issue_pc     = '0;
		issue_insn   = '0;
		issue_tag    = '0;
		src1_busy    = 1'b0;
		src1_val     = '0;
		src2_busy    = 1'b0;
		src2_val     = '0;
		rob_bc_valid = 1'b0;
		rob_bc_tag   = '0;
		rob_bc_value = '0;
		flush_valid  = 1'b0;
		flush_front  = '0;
		flush_tag    = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		repeat (6) run_batch(0);
		repeat (40) run_batch(1);
		repeat (12) run_batch(2);
		repeat (10) run_batch(1);
		$display("errors: value %0d, tag %0d, latency %0d, drain %0d, assertion %0d",
			err_value, err_tag, err_latency, err_drain,
			u_alu_rs_top.u_reservation_station.u_rs_chk.fail_count);
		if (err_value + err_tag + err_latency + err_drain +
				u_alu_rs_top.u_reservation_station.u_rs_chk.fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// budget grows with every issued instruction
	initial begin
		while (cycle_count <= issued_count * 20 + 200) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("watchdog expired after %0d cycles with %0d instructions issued",
			cycle_count, issued_count);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: tb_alu_rs_chk.sv
`timescale 1ns/1ps

module tb_alu_rs_chk #(
	parameter  int rs_size = 8,
	localparam int idx_w   = $clog2(rs_size),
	localparam int cnt_w   = $clog2(rs_size + 1)
) (
	input logic               clk,
	input logic               rst,
	input logic               take_valid,
	input logic [idx_w-1:0]   take_index,
	input logic [rs_size-1:0] ready,
	input logic               dec_valid,
	input logic [cnt_w-1:0]   free_count,
	input logic               cdb_valid
);

	int fail_count = 0;

	// select only picks a ready entry
	take_was_ready: assert property (@(posedge clk) disable iff (rst)
		take_valid |-> ready[take_index])
		else begin
			$error("entry taken while not ready");
			fail_count++;
		end

	free_in_range: assert property (@(posedge clk) disable iff (rst) free_count <= rs_size)
		else begin
			$error("free count above station size");
			fail_count++;
		end

	// issuer protocol, decode never writes into a full station
	write_has_room: assert property (@(posedge clk) disable iff (rst)
		dec_valid |-> free_count != 0)
		else begin
			$error("decoded item arrived with no free entry");
			fail_count++;
		end

	// first cycle out of reset has a quiet result bus
	quiet_after_reset: assert property (@(posedge clk) $past(rst) && !rst |-> !cdb_valid)
		else begin
			$error("result bus active right after reset");
			fail_count++;
		end

endmodule

// File: vlog.f
alu_rs_pkg.sv
issue_decode.sv
reservation_station.sv
issue_select.sv
exec_unit.sv
alu_rs_top.sv
tb_alu_rs_chk.sv
tb_alu_rs.sv
